/* design/lcdPkg.sv */
////////////////////////////////////////////////////////////
// shared definitions for the character LCD controller
// buffer index and data bus types, settle classes
// HD44780 command codes used by the sequencer
////////////////////////////////////////////////////////////

`default_nettype none

package lcdPkg;

    // character buffer geometry
    localparam int charAddrWidth = 5;   // 32 entries, two lines of 16
    localparam int lineLength    = 16;  // characters per display line

    typedef logic [charAddrWidth-1:0] charAddr_t;
    typedef logic [7:0]               lcdData_t;

    // settle time after a command, picked per command by the sequencer
    typedef enum logic [1:0]
    {
        waitShort,  // ordinary commands and character data
        waitMid,    // repeated function sets
        waitLong    // first function set, clears, entry mode
    } waitClass_t;

    // function set: 8-bit bus, two lines, 5x8 font
    localparam lcdData_t cmdFunctionSet = 8'h38;

    // display control
    localparam lcdData_t cmdDisplayOff = 8'h08;
    localparam lcdData_t cmdDisplayOn  = 8'h0C;  // display on, cursor and blink off

    localparam lcdData_t cmdDisplayClear = 8'h01;
    localparam lcdData_t cmdEntryMode    = 8'h06;  // increment, no display shift

    // cursor movement between characters
    localparam lcdData_t cmdCursorShift = 8'h14;  // move right by one
    localparam lcdData_t cmdCursorHome  = 8'h02;

    // DDRAM address commands, the column is added to the base
    localparam lcdData_t cmdLine1Base = 8'h80;
    localparam lcdData_t cmdLine2Base = 8'hC0;  // DDRAM 0x40 is the second line

endpackage

`default_nettype wire

/* design/lcdCycleIf.sv */
////////////////////////////////////////////////////////////
// Wishbone classic link carrying one LCD command
// sequencer is master, bus driver is slave
////////////////////////////////////////////////////////////

`default_nettype none

interface lcdCycleIf
    import lcdPkg::*;
();

    logic       cyc;
    logic       stb;
    lcdData_t   dat;      // command code or character
    logic       rs;       // 0 command, 1 data
    waitClass_t waitSel;  // settle class after the enable pulse
    logic       ack;      // one clock, command fully done

    modport master
    (
        output cyc, stb, dat, rs, waitSel,
        input  ack
    );

    modport slave
    (
        input  cyc, stb, dat, rs, waitSel,
        output ack
    );

endinterface

`default_nettype wire

/* design/charBuffer.sv */
////////////////////////////////////////////////////////////
// 32-entry character memory
// host write port and registered sequencer read port
////////////////////////////////////////////////////////////

`default_nettype none

module charBuffer
    import lcdPkg::*;
(
    input  wire logic      clk,
    input  wire logic      charWrite,
    input  wire charAddr_t writeAddr,
    input  wire lcdData_t  charCode,
    input  wire charAddr_t readAddr,
    output lcdData_t       readData
);

    localparam int depth = 2 ** charAddrWidth;

    // one byte per display position, entries 0 to 15 on line one
    lcdData_t charMem [depth];

    // host side, no back-pressure
    always_ff @(posedge clk)
    begin
        if (charWrite)
        begin
            charMem[writeAddr] <= charCode;
        end
    end

    // read data valid one clock after the address
    always_ff @(posedge clk)
    begin
        readData <= charMem[readAddr];
    end

endmodule

`default_nettype wire

/* design/lcdSequencer.sv */
////////////////////////////////////////////////////////////
// LCD command sequencer
// power-on wait, nine-command init, refresh loop over
// the 32 buffer entries, Wishbone master toward the pins
////////////////////////////////////////////////////////////

`default_nettype none

module lcdSequencer
    import lcdPkg::*;
#(
    parameter int powerOnCycles = 1000000
)
(
    input  wire logic     clk,
    input  wire logic     lcdOnIn,
    output charAddr_t     readAddr,
    input  wire lcdData_t readData,
    lcdCycleIf.master     cyc
);

    localparam int powerOnWidth = $clog2(powerOnCycles + 1);

    // state names the command currently on the bus
    typedef enum logic [3:0]
    {
        stPowerOn,
        stFuncSet,
        stDisplayOff,
        stClearFirst,
        stEntryMode,
        stDisplayOn,
        stClearSecond,
        stWriteAddr,
        stWriteData,
        stCursor
    } seqState_t;

    seqState_t state;
    seqState_t nextState;

    logic [powerOnWidth-1:0] powerOnCount;
    logic [1:0]              funcCount;  // function sets already sent
    logic [1:0]              nextFuncCount;
    charAddr_t               entryIdx;
    charAddr_t               nextEntry;
    logic                    advance;

    lcdData_t   nextDat;
    logic       nextRs;
    waitClass_t nextWait;

    assign advance = (state == stPowerOn) ? (powerOnCount == powerOnWidth'(powerOnCycles - 1))
                                          : cyc.ack;

    // entry address stays put for the whole address command
    assign readAddr = entryIdx;

    always_comb
    begin
        nextState     = state;
        nextFuncCount = funcCount;
        nextEntry     = entryIdx;
        case (state)
            stPowerOn:     nextState = stFuncSet;
            stFuncSet:
            begin
                nextFuncCount = funcCount + 1'b1;
                nextState     = (funcCount == 2'd3) ? stDisplayOff : stFuncSet;
            end
            stDisplayOff:  nextState = stClearFirst;
            stClearFirst:  nextState = stEntryMode;
            stEntryMode:   nextState = stDisplayOn;
            stDisplayOn:   nextState = stClearSecond;
            stClearSecond: nextState = stWriteAddr;
            stWriteAddr:   nextState = stWriteData;
            stWriteData:   nextState = stCursor;
            stCursor:
            begin
                nextState = stWriteAddr;
                nextEntry = entryIdx + 1'b1;  // wraps to 0 after 31
            end
        endcase
    end

    // command for the state being entered
    always_comb
    begin
        nextDat  = cmdDisplayOff;
        nextRs   = 1'b0;
        nextWait = waitShort;
        case (nextState)
            stFuncSet:
            begin
                nextDat  = cmdFunctionSet;
                nextWait = (state == stPowerOn) ? waitLong : waitMid;
            end
            stPowerOn, stDisplayOff: nextDat = cmdDisplayOff;  // power-on never re-entered
            stClearFirst, stClearSecond:
            begin
                nextDat  = cmdDisplayClear;
                nextWait = waitLong;
            end
            stEntryMode:
            begin
                nextDat  = cmdEntryMode;
                nextWait = waitLong;
            end
            stDisplayOn: nextDat = cmdDisplayOn;
            stWriteAddr:
            begin
                if (nextEntry < charAddr_t'(lineLength))
                    nextDat = cmdLine1Base | lcdData_t'(nextEntry);
                else
                    nextDat = cmdLine2Base | lcdData_t'(nextEntry - charAddr_t'(lineLength));
            end
            stWriteData:
            begin
                nextDat = readData;  // address presented a whole command earlier
                nextRs  = 1'b1;
            end
            stCursor: nextDat = (entryIdx == '1) ? cmdCursorHome : cmdCursorShift;
        endcase
    end

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            state        <= stPowerOn;
            powerOnCount <= '0;
            funcCount    <= '0;
            entryIdx     <= '0;
            cyc.cyc      <= 1'b0;
            cyc.stb      <= 1'b0;
        end
        else
        begin
            if (state == stPowerOn)
                powerOnCount <= powerOnCount + 1'b1;
            if (advance)
            begin
                state     <= nextState;
                funcCount <= nextFuncCount;
                entryIdx  <= nextEntry;
                cyc.cyc   <= 1'b1;  // one command always pending once init starts
                cyc.stb   <= 1'b1;
            end
        end
    end

    // payload held until the driver acknowledges
    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            cyc.dat     <= '0;
            cyc.rs      <= 1'b0;
            cyc.waitSel <= waitShort;
        end
        else if (advance)
        begin
            cyc.dat     <= nextDat;
            cyc.rs      <= nextRs;
            cyc.waitSel <= nextWait;
        end
    end

    // driver only completes a command that is actually strobed
    ackNeedsStb: assert property (@(posedge clk) disable iff (!lcdOnIn)
        cyc.ack |-> cyc.stb);

endmodule

`default_nettype wire

/* design/lcdBusDriver.sv */
////////////////////////////////////////////////////////////
// LCD pin driver, Wishbone slave
// latches one command, times the enable pulse and the
// settle delay, then acknowledges
////////////////////////////////////////////////////////////

`default_nettype none

module lcdBusDriver
    import lcdPkg::*;
#(
    parameter int enableCycles    = 26,
    parameter int shortWaitCycles = 2500,
    parameter int midWaitCycles   = 7500,
    parameter int longWaitCycles  = 250000
)
(
    input  wire logic clk,
    input  wire logic lcdOnIn,
    output lcdData_t  lcdBus,
    output logic      lcdRsSelect,
    output logic      lcdEnableOut,
    lcdCycleIf.slave  cyc
);

    // counter sized for the longest of the four delays
    localparam int maxWaitA   = (shortWaitCycles > midWaitCycles) ? shortWaitCycles
                                                                  : midWaitCycles;
    localparam int maxWaitB   = (longWaitCycles > enableCycles) ? longWaitCycles : enableCycles;
    localparam int maxCount   = (maxWaitA > maxWaitB) ? maxWaitA : maxWaitB;
    localparam int countWidth = $clog2(maxCount + 1);

    typedef enum logic [1:0]
    {
        phIdle,
        phPulse,
        phSettle
    } phase_t;

    phase_t                phase;
    logic [countWidth-1:0] count;
    logic [countWidth-1:0] settleLast;
    waitClass_t            settleSel;
    logic                  accept;

    // ack still high means the strobe belongs to the finished command
    assign accept = (phase == phIdle) && cyc.cyc && cyc.stb && !cyc.ack;

    always_comb
    begin
        case (settleSel)
            waitLong: settleLast = countWidth'(longWaitCycles - 1);
            waitMid:  settleLast = countWidth'(midWaitCycles - 1);
            default:  settleLast = countWidth'(shortWaitCycles - 1);
        endcase
    end

    always_ff @(posedge clk or negedge lcdOnIn)
    begin
        if (!lcdOnIn)
        begin
            phase        <= phIdle;
            count        <= '0;
            settleSel    <= waitShort;
            lcdBus       <= '0;
            lcdRsSelect  <= 1'b0;
            lcdEnableOut <= 1'b0;
            cyc.ack      <= 1'b0;
        end
        else
        begin
            cyc.ack <= 1'b0;
            case (phase)
                phIdle:
                begin
                    if (accept)
                    begin
                        lcdBus       <= cyc.dat;
                        lcdRsSelect  <= cyc.rs;
                        settleSel    <= cyc.waitSel;
                        lcdEnableOut <= 1'b1;
                        count        <= '0;
                        phase        <= phPulse;
                    end
                end
                phPulse:
                begin
                    if (count == countWidth'(enableCycles - 1))
                    begin
                        lcdEnableOut <= 1'b0;  // display latches on this falling edge
                        count        <= '0;
                        phase        <= phSettle;
                    end
                    else
                        count <= count + 1'b1;
                end
                phSettle:
                begin
                    if (count == settleLast)
                    begin
                        cyc.ack <= 1'b1;
                        phase   <= phIdle;
                    end
                    else
                        count <= count + 1'b1;
                end
            endcase
        end
    end

    stbNeedsCyc: assert property (@(posedge clk) disable iff (!lcdOnIn)
        cyc.stb |-> cyc.cyc);

    // master holds the command until it has seen ack
    cmdHeld: assert property (@(posedge clk) disable iff (!lcdOnIn)
        cyc.stb && !cyc.ack |=> $stable(cyc.dat) && $stable(cyc.rs) && $stable(cyc.waitSel));

endmodule

`default_nettype wire

/* design/lcdController.sv */
////////////////////////////////////////////////////////////
// character LCD controller top level
// character buffer, command sequencer and pin driver
// joined by one Wishbone command link
////////////////////////////////////////////////////////////

`default_nettype none

module lcdController
    import lcdPkg::*;
#(
    parameter int powerOnCycles   = 1000000,  // 20 ms at 50 MHz
    parameter int enableCycles    = 26,
    parameter int shortWaitCycles = 2500,
    parameter int midWaitCycles   = 7500,
    parameter int longWaitCycles  = 250000
)
(
    input  wire logic      clk,
    input  wire logic      lcdOnIn,          // board switch, also the reset
    input  wire logic      charWrite,
    input  wire charAddr_t writeAddr,
    input  wire lcdData_t  charCode,
    output lcdData_t       lcdBus,
    output logic           lcdOnOut,
    output logic           lcdReadWriteSel,  // 0 write, 1 read
    output logic           lcdRsSelect,      // 0 command, 1 data
    output logic           lcdEnableOut
);

    charAddr_t readAddr;
    lcdData_t  readData;

    lcdCycleIf cmdLink ();

    charBuffer charBuf
    (
        .clk       (clk),
        .charWrite (charWrite),
        .writeAddr (writeAddr),
        .charCode  (charCode),
        .readAddr  (readAddr),
        .readData  (readData)
    );

    lcdSequencer #(
        .powerOnCycles (powerOnCycles)
    ) sequencer
    (
        .clk      (clk),
        .lcdOnIn  (lcdOnIn),
        .readAddr (readAddr),
        .readData (readData),
        .cyc      (cmdLink)
    );

    lcdBusDriver #(
        .enableCycles    (enableCycles),
        .shortWaitCycles (shortWaitCycles),
        .midWaitCycles   (midWaitCycles),
        .longWaitCycles  (longWaitCycles)
    ) busDriver
    (
        .clk          (clk),
        .lcdOnIn      (lcdOnIn),
        .lcdBus       (lcdBus),
        .lcdRsSelect  (lcdRsSelect),
        .lcdEnableOut (lcdEnableOut),
        .cyc          (cmdLink)
    );

    assign lcdOnOut        = lcdOnIn;  // powers the display directly
    assign lcdReadWriteSel = 1'b0;     // busy flag never read

endmodule

`default_nettype wire

/* verif/lcdRefModel.svh */
////////////////////////////////////////////////////////////
// reference model of the LCD command stream
// init list, line address rule, expected (rs, bus) per pulse
////////////////////////////////////////////////////////////

`ifndef LCD_REF_MODEL_SVH
`define LCD_REF_MODEL_SVH

// nine init commands, all sent with rs 0
function automatic lcdData_t initCommand(input int n);
    case (n)
        0, 1, 2, 3: return cmdFunctionSet;
        4:          return cmdDisplayOff;
        5, 8:       return cmdDisplayClear;
        6:          return cmdEntryMode;
        default:    return cmdDisplayOn;
    endcase
endfunction

// line one holds entries 0 to 15, line two the rest
function automatic lcdData_t addressCommand(input int entry);
    if (entry < lineLength)
        return 8'(int'(cmdLine1Base) + entry);
    return 8'(int'(cmdLine2Base) + (entry % lineLength));
endfunction

// expected {rs, bus} for pulse n counted from reset release
function automatic logic [8:0] expectedPulse(input int n, input lcdData_t chars [32]);
    int step;
    int entry;
    if (n < 9)
        return {1'b0, initCommand(n)};
    step  = n - 9;
    entry = (step / 3) % 32;
    case (step % 3)
        0:       return {1'b0, addressCommand(entry)};
        1:       return {1'b1, chars[entry]};
        default: return {1'b0, (entry == 31) ? cmdCursorHome : cmdCursorShift};
    endcase
endfunction

`endif

/* verif/lcdControllerTb.sv */
////////////////////////////////////////////////////////////
// testbench for the character LCD controller
// clock, reset, buffer fill and rewrite, enable pulse
// monitor against the reference model, timeout, report
////////////////////////////////////////////////////////////

`default_nettype none

module lcdControllerTb
    import lcdPkg::*;
();

    localparam int powerOnCycles   = 40;
    localparam int enableCycles    = 3;
    localparam int shortWaitCycles = 4;
    localparam int midWaitCycles   = 6;
    localparam int longWaitCycles  = 9;

    // twice the cycles of two refresh passes and the restart at the slowest command
    localparam int maxCommandCycles = enableCycles + longWaitCycles + 2;
    localparam int cycleLimit = 2 * (2 * powerOnCycles + 32
                                     + (2 * (9 + 32 * 3) + 9) * maxCommandCycles);

    localparam int testInit    = 0;
    localparam int testAddr    = 1;
    localparam int testData    = 2;
    localparam int testCursor  = 3;
    localparam int testTiming  = 4;
    localparam int testRestart = 5;

    logic      clk = 1'b0;
    logic      lcdOnIn;
    logic      charWrite;
    charAddr_t writeAddr;
    lcdData_t  charCode;
    lcdData_t  lcdBus;
    logic      lcdOnOut;
    logic      lcdReadWriteSel;
    logic      lcdRsSelect;
    logic      lcdEnableOut;

    int       seed = 32'h10cd369d;
    lcdData_t charCopy [32];  // what the buffer should hold
    int       checks [6];
    int       errors [6];
    int       pulseIdx = 0;   // completed pulses since the last release
    int       sinceRelease = 0;
    int       highCount = 0;
    logic     prevEnable = 1'b0;
    logic     restarted = 1'b0;
    int       cycleCount = 0;
    int       totalChecks;
    int       totalErrors;

    `include "lcdRefModel.svh"

    lcdController #(
        .powerOnCycles   (powerOnCycles),
        .enableCycles    (enableCycles),
        .shortWaitCycles (shortWaitCycles),
        .midWaitCycles   (midWaitCycles),
        .longWaitCycles  (longWaitCycles)
    ) UUT
    (
        .clk             (clk),
        .lcdOnIn         (lcdOnIn),
        .charWrite       (charWrite),
        .writeAddr       (writeAddr),
        .charCode        (charCode),
        .lcdBus          (lcdBus),
        .lcdOnOut        (lcdOnOut),
        .lcdReadWriteSel (lcdReadWriteSel),
        .lcdRsSelect     (lcdRsSelect),
        .lcdEnableOut    (lcdEnableOut)
    );

    always #5 clk = ~clk;

    function automatic string testName(input int t);
        case (t)
            testInit:   return "initSequence";
            testAddr:   return "lineAddressing";
            testData:   return "characterData";
            testCursor: return "cursorControl";
            testTiming: return "pulseTiming";
            default:    return "resetRestart";
        endcase
    endfunction

    task automatic compareValue(input int t, input int expected, input int actual);
        checks[t] = checks[t] + 1;
        if (expected != actual)
        begin
            errors[t] = errors[t] + 1;
            $display("Fail %s expected %h actual %h", testName(t), expected, actual);
        end
    endtask

    task automatic reportTest(input int t);
        $display("%s: %0d checks, %0d mismatches", testName(t), checks[t], errors[t]);
    endtask

    task automatic checkPulse(input int n);
        logic [8:0] expected;
        int         t;
        expected = expectedPulse(n, charCopy);
        if (n < 9)
            t = restarted ? testRestart : testInit;
        else if ((n - 9) % 3 == 0)
            t = testAddr;
        else if ((n - 9) % 3 == 1)
            t = testData;
        else
            t = testCursor;
        compareValue(t, int'(expected), int'({lcdRsSelect, lcdBus}));
    endtask

    // host write with the shadow copy kept in step
    task automatic writeChar(input int addr, input lcdData_t value);
        @(negedge clk);
        charWrite <= 1'b1;
        writeAddr <= 5'(addr);
        charCode  <= value;
        charCopy[addr] = value;
    endtask

    task automatic waitPulses(input int n);
        do
            @(posedge clk);
        while (pulseIdx < n);
    endtask

    // enable pulse monitor sampling at the falling clock edge
    always @(negedge clk)
    begin
        if (!lcdOnIn)
        begin
            pulseIdx     = 0;
            sinceRelease = 0;
            highCount    = 0;
            prevEnable   = 1'b0;
        end
        else
        begin
            sinceRelease = sinceRelease + 1;
            if (lcdEnableOut && !prevEnable && pulseIdx == 0)
                compareValue(testTiming, powerOnCycles + 1, sinceRelease);
            if (lcdEnableOut)
                highCount = highCount + 1;
            if (!lcdEnableOut && prevEnable)
            begin
                compareValue(testTiming, enableCycles, highCount);
                highCount = 0;
                checkPulse(pulseIdx);
                pulseIdx = pulseIdx + 1;
            end
            prevEnable = lcdEnableOut;
        end
        compareValue(testTiming, 0, int'(lcdReadWriteSel));
        compareValue(testTiming, int'(lcdOnIn), int'(lcdOnOut));
    end

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("run timed out after %0d clock cycles", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    initial
    begin
        lcdOnIn   = 1'b0;
        charWrite = 1'b0;
        writeAddr = '0;
        charCode  = '0;
        for (int i = 0; i < 6; i++)
        begin
            checks[i] = 0;
            errors[i] = 0;
        end

        // fill runs past release but ends long before the first data command
        for (int i = 0; i < 32; i++)
        begin
            writeChar(i, 8'($random(seed)));
            if (i == 15)
                lcdOnIn <= 1'b1;
        end
        @(negedge clk);
        charWrite <= 1'b0;

        // rewrite one entry already shown and one still ahead
        waitPulses(9 + 3 * 8);
        reportTest(testInit);
        writeChar(2, 8'($random(seed)));
        writeChar(20, 8'($random(seed)));
        @(negedge clk);
        charWrite <= 1'b0;

        // full pass until entry 2 is shown again after the wrap
        waitPulses(9 + 96 + 3 * 2 + 3);

        // drop the switch in the middle of a data pulse
        do
            @(negedge clk);
        while (!(lcdEnableOut && lcdRsSelect));
        lcdOnIn <= 1'b0;
        #1;
        compareValue(testRestart, 0, int'(lcdEnableOut));
        compareValue(testRestart, 0, int'(lcdRsSelect));
        compareValue(testRestart, 0, int'(lcdBus));
        repeat (16) @(negedge clk);
        restarted = 1'b1;
        lcdOnIn <= 1'b1;

        waitPulses(15);
        reportTest(testAddr);
        reportTest(testData);
        reportTest(testCursor);
        reportTest(testTiming);
        reportTest(testRestart);

        totalChecks = 0;
        totalErrors = 0;
        for (int i = 0; i < 6; i++)
        begin
            totalChecks = totalChecks + checks[i];
            totalErrors = totalErrors + errors[i];
        end
        $display("total: %0d checks, %0d mismatches", totalChecks, totalErrors);
        if (totalErrors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+verif
design/lcdPkg.sv
design/lcdCycleIf.sv
design/charBuffer.sv
design/lcdSequencer.sv
design/lcdBusDriver.sv
design/lcdController.sv
verif/lcdControllerTb.sv

/* Makefile */
# Verilator build, run, lint and clean for the character LCD controller

TOP = lcdControllerTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "Test failed" sim.log || [ $$status -ne 0 ]; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
